// ==== Makefile ====
TOP = cpuTb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx '>>> PASS' $(LOG)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir $(LOG)

// ==== sources.f ====
src/isaPkg.sv
src/ctrlPkg.sv
src/fetchUnit.sv
src/instrDecoder.sv
src/regFile.sv
src/execUnit.sv
src/controlFsm.sv
src/cpuTop.sv
tb/cpuTop_sva.sv
tb/cpuTb.sv

// ==== src/controlFsm.sv ====
// --------------------
// instruction sequencing FSM
// Moore control word, one state per cycle
// --------------------
`timescale 1ns/100ps

module controlFsm
    import isaPkg::*, ctrlPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  decodedT  dec,
    output ctrlWordT ctrl
);

    stateT state;
    stateT nextState;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stFetch;
        end else begin
            state <= nextState;
        end
    end

    // --------------------
    // next state
    always_comb begin
        nextState = stFetch;
        case (state)
            stFetch: nextState = stLoadIr;
            // dispatch on the word arriving from memory
            stLoadIr: begin
                case (dec.opcode)
                    opMov: begin
                        if (dec.op == movImmOp) begin
                            nextState = stMovImm;
                        end else if (dec.op == movRegOp) begin
                            nextState = stLoadB;
                        end else begin
                            nextState = stPcInc;
                        end
                    end
                    opAlu:   nextState = stLoadB;
                    opLdr:   nextState = (dec.op == memOp) ? stReadRn : stPcInc;
                    opStr:   nextState = (dec.op == memOp) ? stReadRn : stPcInc;
                    // undefined encodings fall through as no-ops
                    default: nextState = stPcInc;
                endcase
            end
            stMovImm: nextState = stPcInc;
            // MOV shifted and MVN need no A operand
            stLoadB: begin
                if (dec.opcode == opMov || dec.op == aluMvn) begin
                    nextState = stComputeB;
                end else begin
                    nextState = stReadRn;
                end
            end
            stComputeB: nextState = stWriteBack;
            stReadRn:   nextState = stLoadA;
            stLoadA: begin
                if (dec.opcode != opAlu) begin
                    nextState = stMemAddr;
                end else if (dec.op == aluCmp) begin
                    nextState = stCompare;
                end else begin
                    nextState = stCompute;
                end
            end
            stCompute:   nextState = stWriteBack;
            stCompare:   nextState = stPcInc;
            stWriteBack: nextState = stPcInc;
            stMemAddr:   nextState = (dec.opcode == opLdr) ? stMemRead : stReadRd;
            stMemRead:   nextState = stLoadWb;
            stLoadWb:    nextState = stPcInc;
            stReadRd:    nextState = stStoreB;
            stStoreB:    nextState = stMemWrite;
            stMemWrite:  nextState = stPcInc;
            stPcInc:     nextState = stFetch;
            default:     nextState = stFetch;
        endcase
    end

    // --------------------
    // control word, all zero unless the state sets it
    always_comb begin
        ctrl = '0;
        case (state)
            stLoadIr: ctrl.loadIr = 1'b1;
            stMovImm: begin
                ctrl.nsel  = selRn;
                ctrl.vsel  = srcImm8;
                ctrl.write = 1'b1;
            end
            stLoadB: begin
                ctrl.nsel  = selRm;
                ctrl.loadB = 1'b1;
            end
            // zero plus shifted B, or inverted B for MVN
            stComputeB: begin
                ctrl.asel  = 1'b1;
                ctrl.loadC = 1'b1;
            end
            stReadRn: ctrl.nsel = selRn;
            stLoadA: begin
                ctrl.nsel  = selRn;
                ctrl.loadA = 1'b1;
            end
            stCompute: ctrl.loadC = 1'b1;
            stCompare: ctrl.loadS = 1'b1;
            stWriteBack: begin
                ctrl.nsel  = selRd;
                ctrl.vsel  = srcC;
                ctrl.write = 1'b1;
            end
            // effective address Rn + sximm5 into C
            stMemAddr: begin
                ctrl.bsel  = 1'b1;
                ctrl.loadC = 1'b1;
            end
            stMemRead: ctrl.msel = 1'b1;
            stLoadWb: begin
                ctrl.nsel  = selRd;
                ctrl.vsel  = srcMdata;
                ctrl.write = 1'b1;
            end
            stReadRd: ctrl.nsel = selRd;
            stStoreB: begin
                ctrl.nsel  = selRd;
                ctrl.loadB = 1'b1;
            end
            stMemWrite: begin
                ctrl.msel   = 1'b1;
                ctrl.mwrite = 1'b1;
            end
            stPcInc: ctrl.loadPc = 1'b1;
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== src/cpuTop.sv ====
// --------------------
// 16-bit multi-cycle RISC core
// memory sits outside behind a synchronous-read port
// --------------------
`timescale 1ns/100ps

module cpuTop
    import isaPkg::*, ctrlPkg::*;
#(
    parameter int addrWidth = 8
) (
    input  logic                 clk,
    input  logic                 rstN,
    output memReqT               memReq,
    input  logic [dataWidth-1:0] memRdata,
    output statusT               status
);

    ctrlWordT             ctrl;
    decodedT              dec;
    logic [dataWidth-1:0] instr;
    logic [dataWidth-1:0] a;
    logic [dataWidth-1:0] b;
    logic [dataWidth-1:0] c;
    logic [addrWidth-1:0] addr;

    fetchUnit #(.addrWidth(addrWidth)) uFetch (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .memRdata(memRdata),
        .c(c), .addr(addr), .instr(instr)
    );

    instrDecoder uDecoder (.instr(instr), .nsel(ctrl.nsel), .dec(dec));

    regFile uRegs (
        .clk(clk), .ctrl(ctrl), .dec(dec), .mdata(memRdata),
        .c(c), .a(a), .b(b)
    );

    execUnit uExec (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .dec(dec),
        .a(a), .b(b), .c(c), .status(status)
    );

    controlFsm uCtrl (.clk(clk), .rstN(rstN), .dec(dec), .ctrl(ctrl));

    // memory port, store data always comes from latch B
    assign memReq.addr  = maxAddrWidth'(addr);
    assign memReq.wdata = b;
    assign memReq.write = ctrl.mwrite;

endmodule

// ==== src/ctrlPkg.sv ====
// --------------------
// controller description of the core
// states, control word, status flags and memory request
// --------------------
package ctrlPkg;

    import isaPkg::*;

    // widest address the memory request can carry
    localparam int maxAddrWidth = 8;

    typedef enum logic [4:0] {
        stFetch, stLoadIr,
        stMovImm, stLoadB, stComputeB,
        stReadRn, stLoadA, stCompute, stCompare, stWriteBack,
        stMemAddr, stMemRead, stLoadWb,
        stReadRd, stStoreB, stMemWrite,
        stPcInc
    } stateT;

    // which instruction field names the register
    typedef enum logic [1:0] {selRn = 2'b00, selRd = 2'b01, selRm = 2'b10} regSelT;

    // register write data source
    typedef enum logic [1:0] {srcMdata = 2'b00, srcImm8 = 2'b01, srcC = 2'b11} writeSrcT;

    // 15-bit control word, one per FSM state
    typedef struct packed {
        regSelT   nsel;
        writeSrcT vsel;
        logic     loadA;
        logic     loadB;
        logic     write;
        logic     asel;
        logic     bsel;
        logic     loadS;
        logic     loadC;
        logic     loadPc;
        logic     msel;
        logic     mwrite;
        logic     loadIr;
    } ctrlWordT;

    typedef struct packed {
        logic overflow;
        logic negative;
        logic zero;
    } statusT;

    typedef struct packed {
        logic [maxAddrWidth-1:0] addr;
        logic [dataWidth-1:0]    wdata;
        logic                    write;
    } memReqT;

endpackage

// ==== src/execUnit.sv ====
// --------------------
// execute unit
// shifter, operand select, ALU, flags, C and status registers
// --------------------
`timescale 1ns/100ps

module execUnit
    import isaPkg::*, ctrlPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  ctrlWordT             ctrl,
    input  decodedT              dec,
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    output logic [dataWidth-1:0] c,
    output statusT               status
);

    logic [dataWidth-1:0] bShift;
    logic [dataWidth-1:0] aIn;
    logic [dataWidth-1:0] bIn;
    logic [dataWidth-1:0] bOp;
    logic [dataWidth:0]   sum;
    logic [dataWidth-1:0] aluOut;
    logic                 isSub;
    logic                 carryIntoSign;
    statusT               statusNext;

    // --------------------
    // shifter and operand select
    always_comb begin
        case (dec.shift)
            shNone:       bShift = b;
            shLeft:       bShift = {b[dataWidth-2:0], 1'b0};
            shRightLogic: bShift = {1'b0, b[dataWidth-1:1]};
            shRightArith: bShift = {b[dataWidth-1], b[dataWidth-1:1]};
            default:      bShift = b;
        endcase
    end

    // asel forces a zero first operand for moves
    assign aIn = ctrl.asel ? '0 : a;
    assign bIn = ctrl.bsel ? dec.sximm5 : bShift;

    // --------------------
    // ALU
    // subtract is add of the inverted operand with carry in
    assign isSub = (dec.op == aluCmp);
    assign bOp   = isSub ? ~bIn : bIn;
    assign sum   = {1'b0, aIn} + {1'b0, bOp} + {{dataWidth{1'b0}}, isSub};

    always_comb begin
        case (dec.op)
            aluAdd:  aluOut = sum[dataWidth-1:0];
            aluCmp:  aluOut = sum[dataWidth-1:0];
            aluAnd:  aluOut = aIn & bIn;
            aluMvn:  aluOut = ~bIn;
            default: aluOut = sum[dataWidth-1:0];
        endcase
    end

    // carry into the sign bit recovered from the sign-bit sum
    assign carryIntoSign = aIn[dataWidth-1] ^ bOp[dataWidth-1] ^ sum[dataWidth-1];

    // overflow only means something for add and subtract
    assign statusNext.overflow = (dec.op == aluAdd || isSub) ?
                                 (carryIntoSign ^ sum[dataWidth]) : 1'b0;
    assign statusNext.negative = aluOut[dataWidth-1];
    assign statusNext.zero     = (aluOut == '0);

    // --------------------
    // result and status registers
    always_ff @(posedge clk) begin
        if (ctrl.loadC) begin
            c <= aluOut;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            status <= '0;
        end else if (ctrl.loadS) begin
            status <= statusNext;
        end
    end

endmodule

// ==== src/fetchUnit.sv ====
// --------------------
// fetch unit
// program counter, instruction register and address select
// --------------------
`timescale 1ns/100ps

module fetchUnit
    import isaPkg::*, ctrlPkg::*;
#(
    parameter int addrWidth = 8
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  ctrlWordT             ctrl,
    input  logic [dataWidth-1:0] memRdata,
    input  logic [dataWidth-1:0] c,
    output logic [addrWidth-1:0] addr,
    output logic [dataWidth-1:0] instr
);

    logic [addrWidth-1:0] pc;
    logic [dataWidth-1:0] ir;

    // program counter, steps by one word
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (ctrl.loadPc) begin
            pc <= pc + addrWidth'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.loadIr) begin
            ir <= memRdata;
        end
    end

    // data accesses use the effective address held in C
    assign addr = ctrl.msel ? c[addrWidth-1:0] : pc;

    // while the IR loads, pass the arriving word on so the FSM can branch on it
    assign instr = ctrl.loadIr ? memRdata : ir;

endmodule

// ==== src/instrDecoder.sv ====
// --------------------
// instruction decoder
// field slicing, immediate sign extension, register select
// --------------------
`timescale 1ns/100ps

module instrDecoder
    import isaPkg::*, ctrlPkg::*;
(
    input  logic [dataWidth-1:0] instr,
    input  regSelT               nsel,
    output decodedT              dec
);

    logic [regNumWidth-1:0] rn;
    logic [regNumWidth-1:0] rd;
    logic [regNumWidth-1:0] rm;

    // opcode 3 | op 2 | Rn 3 | Rd 3 | shift 2 | Rm 3
    assign rn = instr[10:8];
    assign rd = instr[7:5];
    assign rm = instr[2:0];

    assign dec.opcode = opcodeT'(instr[15:13]);
    assign dec.op     = aluOpT'(instr[12:11]);
    assign dec.shift  = shiftT'(instr[4:3]);

    // immediates overlap the Rd, shift and Rm fields
    assign dec.sximm5 = {{(dataWidth - imm5Width){instr[imm5Width-1]}}, instr[imm5Width-1:0]};
    assign dec.sximm8 = {{(dataWidth - imm8Width){instr[imm8Width-1]}}, instr[imm8Width-1:0]};

    // one register number serves both read and write
    always_comb begin
        case (nsel)
            selRn:   dec.regNum = rn;
            selRd:   dec.regNum = rd;
            selRm:   dec.regNum = rm;
            default: dec.regNum = rn;
        endcase
    end

endmodule

// ==== src/isaPkg.sv ====
// --------------------
// instruction set of the 16-bit RISC core
// opcodes, ALU ops, shift codes and the decoded instruction
// --------------------
package isaPkg;

    // word and instruction width, fixed by the instruction format
    localparam int dataWidth   = 16;
    localparam int regNumWidth = 3;
    localparam int imm5Width   = 5;
    localparam int imm8Width   = 8;

    // top three bits of the instruction
    typedef enum logic [2:0] {
        opLdr = 3'b011,
        opStr = 3'b100,
        opAlu = 3'b101,
        opMov = 3'b110
    } opcodeT;

    // op field, bits 12..11
    typedef enum logic [1:0] {
        aluAdd = 2'b00,
        aluCmp = 2'b01,
        aluAnd = 2'b10,
        aluMvn = 2'b11
    } aluOpT;

    // op values under the MOV and memory opcodes
    localparam aluOpT movImmOp = aluAnd;
    localparam aluOpT movRegOp = aluAdd;
    localparam aluOpT memOp    = aluAdd;

    // shift applied to the B operand
    typedef enum logic [1:0] {
        shNone       = 2'b00,
        shLeft       = 2'b01,
        shRightLogic = 2'b10,
        shRightArith = 2'b11
    } shiftT;

    // fields after decode, 42 bits
    typedef struct packed {
        opcodeT                 opcode;
        aluOpT                  op;
        shiftT                  shift;
        logic [regNumWidth-1:0] regNum;
        logic [dataWidth-1:0]   sximm5;
        logic [dataWidth-1:0]   sximm8;
    } decodedT;

endpackage

// ==== src/regFile.sv ====
// --------------------
// register file
// eight general registers and the A and B operand latches
// --------------------
`timescale 1ns/100ps

module regFile
    import isaPkg::*, ctrlPkg::*;
(
    input  logic                 clk,
    input  ctrlWordT             ctrl,
    input  decodedT              dec,
    input  logic [dataWidth-1:0] mdata,
    input  logic [dataWidth-1:0] c,
    output logic [dataWidth-1:0] a,
    output logic [dataWidth-1:0] b
);

    logic [dataWidth-1:0] regs [2**regNumWidth];
    logic [dataWidth-1:0] wdata;
    logic [dataWidth-1:0] rdata;

    // write data select
    always_comb begin
        case (ctrl.vsel)
            srcMdata: wdata = mdata;
            srcImm8:  wdata = dec.sximm8;
            srcC:     wdata = c;
            default:  wdata = c;
        endcase
    end

    // read port follows the selected register number
    assign rdata = regs[dec.regNum];

    always_ff @(posedge clk) begin
        if (ctrl.write) begin
            regs[dec.regNum] <= wdata;
        end
        // operand latches
        if (ctrl.loadA) begin
            a <= rdata;
        end
        if (ctrl.loadB) begin
            b <= rdata;
        end
    end

endmodule

// ==== tb/cpuTb.sv ====
// --------------------
// directed testbench for the 16-bit RISC core
// memory model, reference functions and one task per test
// --------------------
`timescale 1ns/100ps

module cpuTb
    import isaPkg::*, ctrlPkg::*;
();

    localparam int memWords   = 256;
    localparam int numTests   = 6;
    // instructions summed over all test programs
    localparam int totalInstr = 69;
    // doubled worst case of 9 cycles per instruction plus a reset per test
    localparam int watchdogNs = 2 * 10 * (totalInstr * 9 + numTests * 12);

    logic                 clk      = 1'b0;
    logic                 rstN     = 1'b0;
    logic [dataWidth-1:0] memRdata = '0;
    memReqT               memReq;
    statusT               status;

    // image is what reset copies into the memory model
    logic [dataWidth-1:0]    image [memWords];
    logic [dataWidth-1:0]    mem   [memWords];
    logic [maxAddrWidth-1:0] rdAddr;
    memReqT                  storeQ [$];

    logic [maxAddrWidth-1:0] expAddr [$];
    logic [dataWidth-1:0]    expData [$];
    int                      progLen;
    logic [dataWidth-1:0]    rngState   = 16'd64;

    cpuTop #(.addrWidth(8)) DUT (
        .clk(clk), .rstN(rstN), .memReq(memReq), .memRdata(memRdata), .status(status)
    );

    always #5 clk = ~clk;

    // --------------------
    // memory model with one cycle read latency
    always @(posedge clk) begin
        if (!rstN) begin
            mem = image;
            storeQ.delete();
        end else if (memReq.write === 1'b1) begin
            mem[memReq.addr] = memReq.wdata;
            storeQ.push_back(memReq);
        end
        rdAddr <= memReq.addr;
    end

    // read data shows up on the falling edge after the address
    always @(negedge clk) begin
        memRdata <= mem[rdAddr];
    end

    // --------------------
    // reference model
    function automatic logic [dataWidth-1:0] nextRand();
        rngState = rngState ^ (rngState << 7);
        rngState = rngState ^ (rngState >> 9);
        rngState = rngState ^ (rngState << 8);
        return rngState;
    endfunction

    function automatic logic [dataWidth-1:0] sext5(input logic [4:0] v);
        return {{11{v[4]}}, v};
    endfunction

    function automatic logic [dataWidth-1:0] sext8(input logic [7:0] v);
        return {{8{v[7]}}, v};
    endfunction

    // low address bits of Rn + imm5
    function automatic logic [maxAddrWidth-1:0] effAddr(input logic [dataWidth-1:0] base,
                                                        input logic [4:0] imm5);
        return maxAddrWidth'(base + sext5(imm5));
    endfunction

    function automatic logic [dataWidth-1:0] refShift(input logic [dataWidth-1:0] v,
                                                      input shiftT sh);
        case (sh)
            shLeft:       return v << 1;
            shRightLogic: return v >> 1;
            shRightArith: return {v[dataWidth-1], v[dataWidth-1:1]};
            default:      return v;
        endcase
    endfunction

    function automatic logic [dataWidth-1:0] refAlu(input aluOpT op,
                                                    input logic [dataWidth-1:0] a,
                                                    input logic [dataWidth-1:0] b);
        case (op)
            aluAdd:  return a + b;
            aluCmp:  return a - b;
            aluAnd:  return a & b;
            default: return ~b;
        endcase
    endfunction

    // flags of a - b
    // overflow when operand signs differ and the result sign flips
    function automatic statusT refStatus(input logic [dataWidth-1:0] a,
                                         input logic [dataWidth-1:0] b);
        logic [dataWidth-1:0] diff;
        statusT               s;
        diff       = a - b;
        s.overflow = (a[dataWidth-1] != b[dataWidth-1]) && (diff[dataWidth-1] != a[dataWidth-1]);
        s.negative = diff[dataWidth-1];
        s.zero     = (diff == '0);
        return s;
    endfunction

    // --------------------
    // instruction encoders
    function automatic logic [dataWidth-1:0] encReg(input opcodeT opc, input aluOpT op,
                                                    input logic [2:0] rn, input logic [2:0] rd,
                                                    input shiftT sh, input logic [2:0] rm);
        return {opc, op, rn, rd, sh, rm};
    endfunction

    function automatic logic [dataWidth-1:0] encImm(input logic [2:0] rn, input logic [7:0] imm8);
        return {opMov, movImmOp, rn, imm8};
    endfunction

    function automatic logic [dataWidth-1:0] encMem(input opcodeT opc, input logic [2:0] rn,
                                                    input logic [2:0] rd, input logic [4:0] imm5);
        return {opc, memOp, rn, rd, imm5};
    endfunction

    // --------------------
    // test helpers
    task automatic compareWord(input logic [dataWidth-1:0] got,
                               input logic [dataWidth-1:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    task automatic compareStatus(input statusT got, input statusT exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is v=%b n=%b z=%b, expected v=%b n=%b z=%b",
                     $time, what, got.overflow, got.negative, got.zero,
                     exp.overflow, exp.negative, exp.zero);
            $display(">>> FAIL");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    // fill opcode 000 decodes as a no-op
    task automatic startTest();
        for (int i = 0; i < memWords; i++) begin
            image[8'(i)] = {3'b000, i[4:0], i[7:0]};
        end
        expAddr.delete();
        expData.delete();
        progLen = 0;
    endtask

    task automatic addInstr(input logic [dataWidth-1:0] word);
        image[8'(progLen)] = word;
        progLen++;
    endtask

    task automatic placeData(input logic [maxAddrWidth-1:0] a, input logic [dataWidth-1:0] v);
        image[a] = v;
    endtask

    task automatic expectStore(input logic [maxAddrWidth-1:0] a, input logic [dataWidth-1:0] v);
        expAddr.push_back(a);
        expData.push_back(v);
    endtask

    task automatic applyReset();
        @(negedge clk);
        rstN = 1'b0;
        repeat (8) @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic waitStores(input int n);
        while (storeQ.size() < n) begin
            @(negedge clk);
        end
    endtask

    task automatic checkStores();
        foreach (expData[i]) begin
            compareWord(16'(storeQ[i].addr), 16'(expAddr[i]), "store address");
            compareWord(storeQ[i].wdata, expData[i], "store data");
        end
    endtask

    task automatic runProgram();
        applyReset();
        waitStores(expData.size());
        checkStores();
    endtask

    // --------------------
    // directed tests
    task automatic testResetAndSequence();
        startTest();
        addInstr(encImm(3'd0, 8'h05));
        addInstr(encImm(3'd1, 8'h80));
        addInstr(encMem(opStr, 3'd1, 3'd0, 5'd0));
        addInstr(encImm(3'd0, 8'h06));
        addInstr(encMem(opStr, 3'd1, 3'd0, 5'd1));
        // second store only matches if R0 was rewritten in between
        expectStore(effAddr(sext8(8'h80), 5'd0), sext8(8'h05));
        expectStore(effAddr(sext8(8'h80), 5'd1), sext8(8'h06));
        applyReset();
        compareWord(16'(memReq.addr), 16'h0000, "first fetch address");
        compareWord(16'(memReq.write), 16'h0000, "write strobe after reset");
        compareStatus(status, statusT'(3'b000), "status after reset");
        waitStores(2);
        checkStores();
    endtask

    task automatic testMovStore();
        startTest();
        addInstr(encImm(3'd2, 8'h35));
        addInstr(encImm(3'd3, 8'h90));
        addInstr(encMem(opStr, 3'd3, 3'd2, 5'd3));
        addInstr(encImm(3'd4, 8'hC8));
        addInstr(encMem(opStr, 3'd3, 3'd4, 5'h1E));
        expectStore(effAddr(sext8(8'h90), 5'd3), sext8(8'h35));
        expectStore(effAddr(sext8(8'h90), 5'h1E), sext8(8'hC8));
        runProgram();
    endtask

    task automatic testMovShift();
        shiftT sh;
        startTest();
        addInstr(encImm(3'd1, 8'h9B));
        addInstr(encImm(3'd7, 8'h40));
        for (int s = 0; s < 4; s++) begin
            sh = shiftT'(2'(s));
            addInstr(encReg(opMov, movRegOp, 3'd0, 3'd2, sh, 3'd1));
            addInstr(encMem(opStr, 3'd7, 3'd2, 5'(s)));
            expectStore(effAddr(sext8(8'h40), 5'(s)), refShift(sext8(8'h9B), sh));
        end
        runProgram();
    endtask

    task automatic testAluOps();
        logic [7:0]           a8;
        logic [7:0]           b8;
        logic [dataWidth-1:0] r;
        logic [dataWidth-1:0] bs;
        shiftT                sh;
        startTest();
        addInstr(encImm(3'd6, 8'h60));
        for (int k = 0; k < 3; k++) begin
            a8 = 8'(nextRand());
            b8 = 8'(nextRand());
            r  = nextRand();
            sh = shiftT'(r[1:0]);
            bs = refShift(sext8(b8), sh);
            addInstr(encImm(3'd1, a8));
            addInstr(encImm(3'd2, b8));
            addInstr(encReg(opAlu, aluAdd, 3'd1, 3'd3, sh, 3'd2));
            addInstr(encReg(opAlu, aluAnd, 3'd1, 3'd4, sh, 3'd2));
            addInstr(encReg(opAlu, aluMvn, 3'd0, 3'd5, sh, 3'd2));
            addInstr(encMem(opStr, 3'd6, 3'd3, 5'(3 * k)));
            addInstr(encMem(opStr, 3'd6, 3'd4, 5'(3 * k + 1)));
            addInstr(encMem(opStr, 3'd6, 3'd5, 5'(3 * k + 2)));
            expectStore(effAddr(sext8(8'h60), 5'(3 * k)), refAlu(aluAdd, sext8(a8), bs));
            expectStore(effAddr(sext8(8'h60), 5'(3 * k + 1)), refAlu(aluAnd, sext8(a8), bs));
            expectStore(effAddr(sext8(8'h60), 5'(3 * k + 2)), refAlu(aluMvn, '0, bs));
        end
        runProgram();
    endtask

    task automatic testCompare();
        logic [dataWidth-1:0] r3;
        logic [dataWidth-1:0] r4;
        logic [dataWidth-1:0] r5;
        statusT               st1;
        statusT               st2;
        statusT               st3;
        startTest();
        // zero case
        addInstr(encImm(3'd1, 8'h25));
        addInstr(encImm(3'd2, 8'h25));
        addInstr(encImm(3'd7, 8'h70));
        addInstr(encReg(opAlu, aluCmp, 3'd1, 3'd0, shNone, 3'd2));
        addInstr(encMem(opStr, 3'd7, 3'd1, 5'd0));
        st1 = refStatus(sext8(8'h25), refShift(sext8(8'h25), shNone));
        expectStore(effAddr(sext8(8'h70), 5'd0), sext8(8'h25));
        // negative case of 0x10 minus 0x10 shifted left
        addInstr(encImm(3'd1, 8'h10));
        addInstr(encImm(3'd2, 8'h10));
        addInstr(encReg(opAlu, aluCmp, 3'd1, 3'd0, shLeft, 3'd2));
        addInstr(encMem(opStr, 3'd7, 3'd2, 5'd1));
        st2 = refStatus(sext8(8'h10), refShift(sext8(8'h10), shLeft));
        expectStore(effAddr(sext8(8'h70), 5'd1), sext8(8'h10));
        // overflow case of largest positive minus most negative
        addInstr(encImm(3'd0, 8'h00));
        addInstr(encReg(opAlu, aluMvn, 3'd0, 3'd3, shNone, 3'd0));
        addInstr(encReg(opMov, movRegOp, 3'd0, 3'd4, shRightLogic, 3'd3));
        addInstr(encReg(opAlu, aluMvn, 3'd0, 3'd5, shRightLogic, 3'd3));
        addInstr(encReg(opAlu, aluCmp, 3'd4, 3'd0, shNone, 3'd5));
        addInstr(encMem(opStr, 3'd7, 3'd4, 5'd2));
        r3  = refAlu(aluMvn, '0, refShift('0, shNone));
        r4  = refAlu(aluAdd, '0, refShift(r3, shRightLogic));
        r5  = refAlu(aluMvn, '0, refShift(r3, shRightLogic));
        st3 = refStatus(r4, refShift(r5, shNone));
        expectStore(effAddr(sext8(8'h70), 5'd2), r4);
        // flags must survive non-compare instructions
        addInstr(encReg(opAlu, aluAdd, 3'd1, 3'd6, shNone, 3'd2));
        addInstr(encReg(opAlu, aluMvn, 3'd0, 3'd6, shNone, 3'd5));
        addInstr(encMem(opStr, 3'd7, 3'd6, 5'd3));
        expectStore(effAddr(sext8(8'h70), 5'd3), refAlu(aluMvn, '0, r5));
        applyReset();
        waitStores(1);
        compareStatus(status, st1, "status after zero compare");
        waitStores(2);
        compareStatus(status, st2, "status after negative compare");
        waitStores(3);
        compareStatus(status, st3, "status after overflow compare");
        waitStores(4);
        compareStatus(status, st3, "status after add and mvn");
        checkStores();
    endtask

    task automatic testLoad();
        logic [dataWidth-1:0] d1;
        logic [dataWidth-1:0] d2;
        startTest();
        d1 = nextRand();
        d2 = nextRand();
        placeData(effAddr(sext8(8'hA0), 5'd5), d1);
        placeData(effAddr(sext8(8'h50), 5'h1C), d2);
        addInstr(encImm(3'd1, 8'hA0));
        addInstr(encMem(opLdr, 3'd1, 3'd2, 5'd5));
        addInstr(encImm(3'd3, 8'h50));
        addInstr(encMem(opStr, 3'd3, 3'd2, 5'h1F));
        addInstr(encMem(opLdr, 3'd3, 3'd4, 5'h1C));
        addInstr(encMem(opStr, 3'd1, 3'd4, 5'd7));
        expectStore(effAddr(sext8(8'h50), 5'h1F), d1);
        expectStore(effAddr(sext8(8'hA0), 5'd7), d2);
        runProgram();
    endtask

    // --------------------
    // watchdog
    initial begin
        #(watchdogNs);
        $display("watchdog expired before the expected stores appeared");
        $display(">>> FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        rstN = 1'b0;
        testResetAndSequence();
        testMovStore();
        testMovShift();
        testAluOps();
        testCompare();
        testLoad();
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== tb/cpuTop_sva.sv ====
// --------------------
// memory port assertions
// bound to the core top level
// --------------------
`timescale 1ns/100ps

module cpuTopSva
    import ctrlPkg::*;
(
    input logic   clk,
    input logic   rstN,
    input memReqT memReq
);

    // one edge after reset is seen the FSM sits in fetch
    assert property (@(posedge clk) !rstN |=> !memReq.write)
        else $error("memory write strobe high during reset");

    // a store is a single-cycle strobe
    assert property (@(posedge clk) disable iff (!rstN) memReq.write |=> !memReq.write)
        else $error("memory write strobe held for two cycles");

    assert property (@(posedge clk) disable iff (!rstN)
                     memReq.write |-> !$isunknown({memReq.addr, memReq.wdata}))
        else $error("unknown address or data on a memory write");

endmodule

bind cpuTop cpuTopSva uSva (.clk(clk), .rstN(rstN), .memReq(memReq));
